/* compile.f */
+incdir+.
statsPkg.sv
statsControl.sv
extremeTracker.sv
sampleDelayLine.sv
averageSelect.sv
apbStatusRegs.sv
sampleStatsTop.sv
statsChecker.sv
stats_assert.sv
tbSampleStats.sv

/* tbSampleStats.sv */
/*
  Testbench for the statistics unit. Rows are applied one per clock; a row
  with an APB operation must be followed by a row without one.
*/
`timescale 1ns/1ns
`include "stats_macros.svh"

module tbSampleStats
    import statsPkg::*;
;

    typedef struct packed {
        logic [7:0]  data;
        logic        en;
        logic        avg;
        logic        rst;
        logic [1:0]  op;  // 0 none, 1 read, 2 write
        logic [3:0]  addr;
        logic [31:0] wdata;
    } rowT;

    logic       CLOCK;
    logic       rstN;
    sampleInT   sampleIn;
    apbReqT     apbReq;
    logic [7:0] dataOut;
    apbRspT     apbRsp;
    int         checkErrors;
    int         tbErrors;
    integer     seed;
    rowT        rows[$];

    sampleStatsTop i_sampleStatsTop (
        .CLOCK    (CLOCK),
        .rstN     (rstN),
        .sampleIn (sampleIn),
        .apbReq   (apbReq),
        .dataOut  (dataOut),
        .apbRsp   (apbRsp)
    );

    statsChecker i_statsChecker (
        .CLOCK    (CLOCK),
        .rstN     (rstN),
        .sampleIn (sampleIn),
        .apbReq   (apbReq),
        .dataOut  (dataOut),
        .apbRsp   (apbRsp),
        .errCount (checkErrors)
    );

    initial begin
        CLOCK = 1'b0;
        forever #4 CLOCK = ~CLOCK;
    end

    task automatic addRow(input logic [7:0] d, input logic [2:0] ctl,
                          input logic [1:0] op = 0, input logic [3:0] addr = 0,
                          input logic [31:0] wdata = 0);
        rows.push_back('{d, ctl[2], ctl[1], ctl[0], op, addr, wdata});
    endtask

    // pready is tied high, so this returns at once unless it breaks
    task automatic waitReady();
        int waited;
        waited = 0;
        while (!apbRsp.pready && waited < 16) begin
            @(posedge CLOCK);
            #1;
            waited++;
        end
        if (!apbRsp.pready) begin
            $display("APB slave never raised pready");
            tbErrors++;
        end
    endtask

    task automatic buildTable();
        logic [31:0] r;
        addRow(8'h00, 3'b000);                   // idle cycle
        addRow(8'h15, 3'b100);                   // captured
        addRow(8'h20, 3'b100, 1, `REG_EXTREMES);
        addRow(8'h70, 3'b100);
        addRow(8'h7f, 3'b100);
        addRow(8'h60, 3'b100);                   // overflowing sums
        addRow(8'h90, 3'b100);
        addRow(8'h85, 3'b100);
        addRow(8'hf1, 3'b100);
        addRow(8'h81, 3'b100);                   // negative sums
        addRow(8'h81, 3'b100);
        for (int i = 0; i < 5; i++) addRow(8'h11 * i, 3'b110);  // delayed
        for (int i = 0; i < 10; i++) begin
            r = $random(seed);
            addRow(r[7:0], {1'b1, r[9], 1'b0});
        end
        addRow(8'h64, 3'b100);
        addRow(8'h9c, 3'b100);
        addRow(8'h05, 3'b001);                   // midrange
        addRow(8'h77, 3'b000);
        addRow(8'h12, 3'b000, 1, `REG_LAST);     // hold last
        addRow(8'h34, 3'b000);
        addRow(8'h33, 3'b100, 2, `REG_CTRL, 32'h1);
        addRow(8'h44, 3'b100);
        addRow(8'h55, 3'b100);                   // captured again
        addRow(8'h66, 3'b100, 1, `REG_EXTREMES);
        addRow(8'h01, 3'b100);
        addRow(8'h02, 3'b100, 1, `REG_STATUS);
        addRow(8'h03, 3'b100);
        addRow(8'h04, 3'b100, 1, 4'h2);          // unmapped
        addRow(8'h05, 3'b100);
        addRow(8'h06, 3'b100, 2, `REG_LAST, 32'h5);
        addRow(8'h07, 3'b100);
        for (int i = 0; i < 6; i++) begin
            r = $random(seed);
            addRow(r[7:0], {r[8], r[9], r[10]});
        end
    endtask

    initial begin
        logic inAccess;
        seed      = 32'hd341_eca9;
        tbErrors  = 0;
        rstN      = 1'b0;
        sampleIn  = '0;
        apbReq    = '0;
        inAccess  = 1'b0;
        buildTable();
        repeat (8) @(posedge CLOCK);
        #1;
        rstN = 1'b1;
        foreach (rows[i]) begin
            sampleIn = '{rows[i].data, rows[i].en, rows[i].avg, rows[i].rst};
            if (inAccess) begin
                apbReq.penable = 1'b1;
                inAccess = 1'b0;
                waitReady();
            end else if (rows[i].op != 0) begin
                apbReq = '{1'b1, 1'b0, rows[i].op == 2, rows[i].addr, rows[i].wdata};
                inAccess = 1'b1;
            end else begin
                apbReq = '0;
            end
            @(posedge CLOCK);
            #1;
        end
        apbReq = '0;
        repeat (4) @(posedge CLOCK);
        $display("checker errors %0d, testbench errors %0d", checkErrors, tbErrors);
        if (checkErrors == 0 && tbErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #100000;
        $display("run did not finish in time");
        $display("sim failed");
        $finish;
    end

endmodule

/* stats_assert.sv */
/*
  Concurrent checks bound into the top level. They look at internal
  wires (state, recapture) as well as the ports.
*/
`timescale 1ns/1ns
`include "stats_macros.svh"

module statsAssert
    import statsPkg::*;
(
    input logic                CLOCK,
    input logic                rstN,
    input apbRspT              apbRsp,
    input logic                recapture,
    input ctrlStateE           state,
    input logic [`STATS_W-1:0] dataOut
);

    // zero-wait slave
    readyHigh: assert property (@(posedge CLOCK) disable iff (!rstN) apbRsp.pready)
        else $error("pready dropped low");

    recapturePulse: assert property (@(posedge CLOCK) disable iff (!rstN)
        recapture |=> !recapture)
        else $error("recapture held longer than one cycle");

    // the first capture cycle still shows the last run output
    zeroOutsideRun: assert property (@(posedge CLOCK) disable iff (!rstN)
        (state != ST_RUN && $past(state) != ST_RUN) |-> dataOut == '0)
        else $error("dataOut nonzero outside the run state");

endmodule

bind sampleStatsTop statsAssert i_statsAssert (
    .CLOCK     (CLOCK),
    .rstN      (rstN),
    .apbRsp    (apbRsp),
    .recapture (recapture),
    .state     (state),
    .dataOut   (dataOut)
);

/* statsChecker.sv */
/*
  Reference model of the statistics unit, driven from the DUT ports only.
  Model updates on the rising edge, comparisons on the falling edge.
*/
`timescale 1ns/1ns
`include "stats_macros.svh"

module statsChecker
    import statsPkg::*;
(
    input  logic                CLOCK,
    input  logic                rstN,
    input  sampleInT            sampleIn,
    input  apbReqT              apbReq,
    input  logic [`STATS_W-1:0] dataOut,
    input  apbRspT              apbRsp,
    output int                  errCount
);

    logic [1:0]  mState;  // 0 idle, 1 capture, 2 run
    logic [7:0]  mMax, mMin, mLast, mOut;
    logic [7:0]  mHist [4];  // mHist[3] is four cycles old
    logic        mRecap;
    logic [31:0] mPrdata;
    logic        mSlverr;

    // rounding average, worked in integers
    function automatic logic [7:0] expectAvg(input logic [7:0] a, input logic [7:0] b);
        int sum;
        int mag;
        int half;
        sum = $signed(a) + $signed(b);
        if (sum >= 0) begin
            return (sum / 2) % 64;
        end
        mag  = (256 - (sum & 127)) % 256;
        half = (mag >= 128) ? ((mag >> 1) | 128) : (mag >> 1);
        return (256 - half) % 256;
    endfunction

    always @(posedge CLOCK or negedge rstN) begin
        logic setup;
        logic known;
        logic newRecap;
        if (!rstN) begin
            mState  = 0;
            mMax    = 0;
            mMin    = 0;
            mLast   = 0;
            mOut    = 0;
            mRecap  = 0;
            mPrdata = 0;
            mSlverr = 0;
            for (int i = 0; i < 4; i++) mHist[i] = 0;
        end else begin
            setup    = apbReq.psel && !apbReq.penable;
            known    = apbReq.paddr inside {4'h0, 4'h4, 4'h8, 4'hC};
            newRecap = setup && apbReq.pwrite && apbReq.paddr == 4'h0 && apbReq.pwdata[0];
            mSlverr  = setup && (!known || (apbReq.pwrite && apbReq.paddr != 4'h0));
            mPrdata  = 0;
            if (setup && !apbReq.pwrite) begin  // sees values before this edge
                case (apbReq.paddr)
                    4'h4: mPrdata = {16'h0, mMax, mMin};
                    4'h8: mPrdata = {24'h0, mLast};
                    4'hC: mPrdata = {30'h0, mState};
                    default: mPrdata = 0;
                endcase
            end
            case (mState)
                0: begin
                    mOut   = 0;
                    mState = 1;
                end
                1: begin
                    mMax   = sampleIn.data;
                    mMin   = sampleIn.data;
                    mLast  = 0;
                    mOut   = 0;
                    mState = 2;
                    for (int i = 0; i < 4; i++) mHist[i] = 0;
                end
                default: begin
                    if (sampleIn.restart) mOut = expectAvg(mMax, mMin);
                    else if (sampleIn.enable && sampleIn.average) mOut = mHist[3];
                    else if (sampleIn.enable) mOut = expectAvg(sampleIn.data, mHist[3]);
                    else mOut = mLast;
                    for (int i = 3; i > 0; i--) mHist[i] = mHist[i-1];
                    mHist[0] = sampleIn.data;
                    if (sampleIn.enable) mLast = sampleIn.data;
                    if ($signed(sampleIn.data) > $signed(mMax)) mMax = sampleIn.data;
                    else if ($signed(mMin) > $signed(sampleIn.data)) mMin = sampleIn.data;
                    if (mRecap) mState = 1;  // pulse seen at this edge
                end
            endcase
            mRecap = newRecap;
        end
    end

    initial errCount = 0;

    // output is held at zero through reset as well
    always @(negedge CLOCK) begin
        if (dataOut !== mOut) begin
            $display("ERR dataOut expected %h got %h", mOut, dataOut);
            errCount++;
        end
        if (apbReq.psel && apbReq.penable) begin
            if (apbRsp.prdata !== mPrdata) begin
                $display("ERR prdata expected %h got %h", mPrdata, apbRsp.prdata);
                errCount++;
            end
            if (apbRsp.pslverr !== mSlverr) begin
                $display("ERR pslverr expected %h got %h", mSlverr, apbRsp.pslverr);
                errCount++;
            end
        end
    end

endmodule

/* sampleStatsTop.sv */
/*
  Streaming statistics unit, one signed sample per clock with no handshake.
  APB carries status reads and the re-capture request only.
*/
`timescale 1ns/1ns
`include "stats_macros.svh"

module sampleStatsTop
    import statsPkg::*;
(
    input  logic                CLOCK,
    input  logic                rstN,
    input  sampleInT            sampleIn,
    input  apbReqT              apbReq,
    output logic [`STATS_W-1:0] dataOut,
    output apbRspT              apbRsp
);

    ctrlStateE           state;
    outSelE              outSel;
    logic                capture;
    logic                running;
    logic                recapture;
    logic [`STATS_W-1:0] maxVal;
    logic [`STATS_W-1:0] minVal;
    logic [`STATS_W-1:0] oldest;
    logic [`STATS_W-1:0] lastVal;

    statsControl i_statsControl (
        .CLOCK     (CLOCK),
        .rstN      (rstN),
        .sampleIn  (sampleIn),
        .recapture (recapture),
        .state     (state),
        .capture   (capture),
        .running   (running),
        .outSel    (outSel)
    );

    extremeTracker i_extremeTracker (
        .CLOCK   (CLOCK),
        .rstN    (rstN),
        .capture (capture),
        .running (running),
        .data    (sampleIn.data),
        .maxVal  (maxVal),
        .minVal  (minVal)
    );

    sampleDelayLine i_sampleDelayLine (
        .CLOCK    (CLOCK),
        .rstN     (rstN),
        .capture  (capture),
        .running  (running),
        .sampleIn (sampleIn),
        .oldest   (oldest),
        .lastVal  (lastVal)
    );

    averageSelect i_averageSelect (
        .CLOCK   (CLOCK),
        .rstN    (rstN),
        .outSel  (outSel),
        .data    (sampleIn.data),
        .maxVal  (maxVal),
        .minVal  (minVal),
        .oldest  (oldest),
        .lastVal (lastVal),
        .dataOut (dataOut)
    );

    apbStatusRegs i_apbStatusRegs (
        .CLOCK     (CLOCK),
        .rstN      (rstN),
        .apbReq    (apbReq),
        .state     (state),
        .maxVal    (maxVal),
        .minVal    (minVal),
        .lastVal   (lastVal),
        .apbRsp    (apbRsp),
        .recapture (recapture)
    );

endmodule

/* apbStatusRegs.sv */
/*
  Zero-wait APB slave for status reads. The response is registered in the
  setup cycle so it is valid in the access cycle; pready is tied high.
*/
`timescale 1ns/1ns
`include "stats_macros.svh"

module apbStatusRegs
    import statsPkg::*;
(
    input  logic                CLOCK,
    input  logic                rstN,
    input  apbReqT              apbReq,
    input  ctrlStateE           state,
    input  logic [`STATS_W-1:0] maxVal,
    input  logic [`STATS_W-1:0] minVal,
    input  logic [`STATS_W-1:0] lastVal,
    output apbRspT              apbRsp,
    output logic                recapture
);

    logic        setupPhase;
    logic        knownOffset;
    logic        ctrlHit;
    logic        accessErr;
    logic [31:0] readData;
    logic [31:0] prdataQ;
    logic        pslverrQ;

    assign setupPhase = apbReq.psel && !apbReq.penable;
    assign ctrlHit    = (apbReq.paddr == `REG_CTRL);

    // read mux over the register map
    always_comb begin
        readData    = '0;
        knownOffset = 1'b1;
        case (apbReq.paddr)
            `REG_CTRL: begin
                readData = '0;  // write-only trigger
            end
            `REG_EXTREMES: begin
                readData[15:0] = {maxVal, minVal};
            end
            `REG_LAST: begin
                readData[7:0] = lastVal;
            end
            `REG_STATUS: begin
                readData[1:0] = state;
            end
            default: begin
                knownOffset = 1'b0;
            end
        endcase
    end

    // only the control register accepts writes
    assign accessErr = !knownOffset || (apbReq.pwrite && !ctrlHit);

    always_ff @(posedge CLOCK or negedge rstN) begin
        if (!rstN) begin
            prdataQ   <= '0;
            pslverrQ  <= 1'b0;
            recapture <= 1'b0;
        end else begin
            prdataQ   <= (setupPhase && !apbReq.pwrite) ? readData : '0;
            pslverrQ  <= setupPhase && accessErr;
            // high for the access cycle only
            recapture <= setupPhase && apbReq.pwrite && ctrlHit && apbReq.pwdata[0];
        end
    end

    assign apbRsp = '{prdata: prdataQ, pready: 1'b1, pslverr: pslverrQ};

endmodule

/* averageSelect.sv */
/*
  Rounding averagers and the registered output mux. Negative sums round
  through a negate, shift, negate sequence, so results are not a plain floor.
*/
`timescale 1ns/1ns
`include "stats_macros.svh"

module averageSelect
    import statsPkg::*;
(
    input  logic                CLOCK,
    input  logic                rstN,
    input  outSelE              outSel,
    input  logic [`STATS_W-1:0] data,
    input  logic [`STATS_W-1:0] maxVal,
    input  logic [`STATS_W-1:0] minVal,
    input  logic [`STATS_W-1:0] oldest,
    input  logic [`STATS_W-1:0] lastVal,
    output logic [`STATS_W-1:0] dataOut
);

    logic [`STATS_W-1:0] midrange;
    logic [`STATS_W-1:0] smooth;

    // averaging of two signed samples, 8-bit result
    function automatic logic [`STATS_W-1:0] avgRound(
        input logic [`STATS_W-1:0] a,
        input logic [`STATS_W-1:0] b
    );
        logic [`STATS_W:0]   sum;
        logic [`STATS_W-1:0] negLow;
        logic [`STATS_W-1:0] halved;
        sum = {a[`STATS_W-1], a} + {b[`STATS_W-1], b};
        if (!sum[`STATS_W]) begin
            avgRound = {2'b00, sum[`STATS_W-2:1]};
        end else begin
            negLow   = -{1'b0, sum[`STATS_W-2:0]};  // magnitude of low bits
            halved   = {negLow[`STATS_W-1], negLow[`STATS_W-1:1]};
            avgRound = -halved;
        end
    endfunction

    assign midrange = avgRound(maxVal, minVal);
    assign smooth   = avgRound(data, oldest);

    always_ff @(posedge CLOCK or negedge rstN) begin
        if (!rstN) begin
            dataOut <= '0;
        end else begin
            case (outSel)
                OUT_MIDRANGE: dataOut <= midrange;
                OUT_DELAYED:  dataOut <= oldest;
                OUT_SMOOTH:   dataOut <= smooth;
                OUT_LAST:     dataOut <= lastVal;  // old value when enable is low
                default:      dataOut <= '0;       // idle and capture
            endcase
        end
    end

endmodule

/* sampleDelayLine.sv */
/*
  Sample history of HIST_DEPTH stages and the last enabled sample.
  Both clear on capture; the history shifts on every run cycle.
*/
`timescale 1ns/1ns
`include "stats_macros.svh"

module sampleDelayLine
    import statsPkg::*;
(
    input  logic                CLOCK,
    input  logic                rstN,
    input  logic                capture,
    input  logic                running,
    input  sampleInT            sampleIn,
    output logic [`STATS_W-1:0] oldest,
    output logic [`STATS_W-1:0] lastVal
);

    logic [`STATS_W-1:0] hist [`HIST_DEPTH];  // hist[0] is the newest

    always_ff @(posedge CLOCK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `HIST_DEPTH; i++) begin
                hist[i] <= '0;
            end
            lastVal <= '0;
        end else if (capture) begin
            for (int i = 0; i < `HIST_DEPTH; i++) begin
                hist[i] <= '0;
            end
            lastVal <= '0;
        end else if (running) begin
            hist[0] <= sampleIn.data;
            for (int i = 1; i < `HIST_DEPTH; i++) begin
                hist[i] <= hist[i-1];
            end
            if (sampleIn.enable) begin
                lastVal <= sampleIn.data;
            end
        end
    end

    assign oldest = hist[`HIST_DEPTH-1];  // sample from HIST_DEPTH cycles ago

endmodule

/* extremeTracker.sv */
/*
  Running signed maximum and minimum. A sample updates at most one of them,
  the maximum taking precedence.
*/
`timescale 1ns/1ns
`include "stats_macros.svh"

module extremeTracker (
    input  logic                CLOCK,
    input  logic                rstN,
    input  logic                capture,
    input  logic                running,
    input  logic [`STATS_W-1:0] data,
    output logic [`STATS_W-1:0] maxVal,
    output logic [`STATS_W-1:0] minVal
);

    logic aboveMax;
    logic belowMin;

    // two's complement compares against the stored values
    assign aboveMax = $signed(data) > $signed(maxVal);
    assign belowMin = $signed(minVal) > $signed(data);

    always_ff @(posedge CLOCK or negedge rstN) begin
        if (!rstN) begin
            maxVal <= '0;
            minVal <= '0;
        end else if (capture) begin
            maxVal <= data;  // first sample seeds both
            minVal <= data;
        end else if (running) begin
            if (aboveMax) begin
                maxVal <= data;
            end else if (belowMin) begin
                minVal <= data;
            end
        end
    end

endmodule

/* statsControl.sv */
/*
  Idle, capture and run sequencing plus the output opcode decode.
  The opcode is combinational so the datapath registers it on the same edge.
*/
`timescale 1ns/1ns

module statsControl
    import statsPkg::*;
(
    input  logic      CLOCK,
    input  logic      rstN,
    input  sampleInT  sampleIn,
    input  logic      recapture,
    output ctrlStateE state,
    output logic      capture,
    output logic      running,
    output outSelE    outSel
);

    ctrlStateE nextState;

    always_comb begin
        nextState = state;
        case (state)
            ST_IDLE: begin
                nextState = ST_CAPTURE;  // single idle cycle after reset
            end
            ST_CAPTURE: begin
                nextState = ST_RUN;
            end
            ST_RUN: begin
                if (recapture) begin
                    nextState = ST_CAPTURE;  // software asked for a fresh seed
                end
            end
            default: begin
                nextState = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLOCK or negedge rstN) begin
        if (!rstN) begin
            state <= ST_IDLE;
        end else begin
            state <= nextState;
        end
    end

    assign capture = (state == ST_CAPTURE);
    assign running = (state == ST_RUN);

    // priority: restart, then enable with average, then enable, else hold
    always_comb begin
        if (!running) begin
            outSel = OUT_ZERO;
        end else if (sampleIn.restart) begin
            outSel = OUT_MIDRANGE;
        end else if (sampleIn.enable && sampleIn.average) begin
            outSel = OUT_DELAYED;
        end else if (sampleIn.enable) begin
            outSel = OUT_SMOOTH;
        end else begin
            outSel = OUT_LAST;
        end
    end

endmodule

/* statsPkg.sv */
/*
  Shared types for the statistics unit: stream and APB structs, FSM states
  and output opcodes. Widths come from the macro header.
*/
`include "stats_macros.svh"

package statsPkg;

    // one cycle of input, no handshake
    typedef struct packed {
        logic [`STATS_W-1:0] data;  // two's complement sample
        logic                enable;
        logic                average;
        logic                restart;
    } sampleInT;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [`APB_AW-1:0] paddr;
        logic [31:0]       pwdata;
    } apbReqT;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRspT;

    // encoding is visible through the status register
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_CAPTURE = 2'd1,
        ST_RUN     = 2'd2
    } ctrlStateE;

    typedef enum logic [2:0] {
        OUT_ZERO,
        OUT_MIDRANGE,
        OUT_DELAYED,
        OUT_SMOOTH,
        OUT_LAST
    } outSelE;

endpackage

/* stats_macros.svh */
/*
  Widths and offsets for the sample statistics unit. Only 8-bit samples and
  a 4-deep history are supported; the APB offsets assume a 4-bit address.
*/
`ifndef STATS_MACROS_SVH
`define STATS_MACROS_SVH

// sample width in bits
`define STATS_W 8

// number of history stages
`define HIST_DEPTH 4

// APB address width
`define APB_AW 4

// register byte offsets
`define REG_CTRL     4'h0
`define REG_EXTREMES 4'h4
`define REG_LAST     4'h8
`define REG_STATUS   4'hC

`endif
